// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := synth_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
verilog/synth_pkg.sv
verilog/wave_rom.sv
verilog/envelope_gen.sv
verilog/voice_osc.sv
verilog/note_dispatch.sv
verilog/voice_mixer.sv
verilog/synth_top.sv
dv/synth_checker.sv
dv/synth_tb.sv

// ==== dv/synth_checker.sv ====
module synth_checker (
    input  logic                             ms_clk,
    input  logic                             arst_n,
    input  synth_pkg::note_cmd_t             cmd,
    input  logic                             cmd_valid,
    input  logic                             cmd_credit,
    input  synth_pkg::sample_t               audio_out,
    input  logic [synth_pkg::NUM_VOICES-1:0] voice_busy,
    input  logic                             steady,        // Row expects a settled tone
    input  logic                             run_done,
    output int                               error_count
);

    localparam int SETTLE = 2 * synth_pkg::TICK_DIV + 4;    // Two ticks to full gain, plus pipe
    // Full-scale square after gain scaling, floor of the product over 2^GAIN_W
    localparam longint SQ_HI =
        (longint'(synth_pkg::SAMPLE_MAX) * synth_pkg::GAIN_MAX) >>> synth_pkg::GAIN_W;
    localparam longint SQ_LO =
        (longint'(-synth_pkg::SAMPLE_MAX) * synth_pkg::GAIN_MAX) >>> synth_pkg::GAIN_W;

    synth_pkg::note_cmd_t   pend_q [$];                      // Sent, not yet credited
    synth_pkg::note_cmd_t   popped;
    logic                   act      [synth_pkg::NUM_VOICES]; // Voice holds a note
    synth_pkg::wave_shape_e shp      [synth_pkg::NUM_VOICES];
    synth_pkg::phase_t      frq      [synth_pkg::NUM_VOICES];
    int                     rel_left [synth_pkg::NUM_VOICES]; // Cycles left to go idle
    synth_pkg::phase_t      ph_model;                        // Phase of the last started voice
    synth_pkg::phase_t      ph_d1;
    synth_pkg::phase_t      ph_d2;
    synth_pkg::phase_t      ph_d3;                           // Lines up with audio_out
    int                     last_on;
    int                     settle;
    int                     idle_run;
    int                     pinned;
    int                     sat_total;
    int                     check_count;
    logic                   steady_q;
    logic                   reported;

    // Worst case ticks to fall from full gain, plus one tick of phase
    function automatic int release_limit(input synth_pkg::rate_t r);
        int step;
        step = ((r == 0) ? 1 : int'(r)) * 256;
        return ((synth_pkg::GAIN_MAX + step - 1) / step + 1) * synth_pkg::TICK_DIV;
    endfunction

    task automatic expect_true(input logic ok, input string msg);
        check_count++;
        if (!ok) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    always @(posedge ms_clk) begin : watch
        int   n_act;
        int   a;
        int   b;
        logic on_credit;
        if (!arst_n) begin
            pend_q.delete();
            for (int v = 0; v < synth_pkg::NUM_VOICES; v++) begin
                act[v]      = 1'b0;
                shp[v]      = synth_pkg::SHAPE_SINE;
                frq[v]      = '0;
                rel_left[v] = 0;
            end
            {ph_model, ph_d1, ph_d2, ph_d3} = '0;
            {last_on, settle, idle_run, pinned, sat_total} = '0;
            steady_q = 1'b0;
        end else begin
            // Release deadlines run down while the voice stays busy
            for (int v = 0; v < synth_pkg::NUM_VOICES; v++) begin
                if (rel_left[v] > 0) begin
                    rel_left[v] = voice_busy[v] ? rel_left[v] - 1 : 0;
                    if (voice_busy[v] && rel_left[v] == 0)
                        expect_true(1'b0, $sformatf("voice %0d busy past release limit", v));
                end
            end
            // Credits come back in send order
            on_credit = 1'b0;
            if (cmd_credit) begin
                expect_true(pend_q.size() > 0, "credit with no command outstanding");
                if (pend_q.size() > 0) begin
                    popped = pend_q.pop_front();
                    if (popped.op == synth_pkg::OP_NOTE_ON) begin
                        act[popped.voice] = 1'b1;
                        shp[popped.voice] = popped.shape;
                        frq[popped.voice] = popped.freq;
                        last_on   = popped.voice;
                        on_credit = 1'b1;                    // Voice phase clears now
                        settle    = 0;
                    end else begin
                        act[popped.voice]      = 1'b0;
                        rel_left[popped.voice] = release_limit(popped.release_rate);
                    end
                end
            end
            if (cmd_valid) begin
                pend_q.push_back(cmd);
                expect_true(pend_q.size() <= synth_pkg::CMD_FIFO_DEPTH,
                            "more commands outstanding than FIFO entries");
            end
            // Silence once the last voice has been idle through the pipe
            idle_run = (voice_busy == '0) ? idle_run + 1 : 0;
            if (idle_run >= 3)
                expect_true(audio_out == 0, "audio not zero while all voices idle");
            if (steady != steady_q) settle = 0;
            steady_q = steady;
            n_act = 0;
            a     = 0;
            b     = 0;
            for (int v = synth_pkg::NUM_VOICES - 1; v >= 0; v--) begin
                if (act[v]) begin
                    n_act++;
                    b = a;
                    a = v;                                   // a is the lowest active voice
                end
            end
            if (steady && settle >= SETTLE) begin
                if (n_act == 1 && shp[a] == synth_pkg::SHAPE_SQUARE) begin
                    expect_true(audio_out == SQ_HI || audio_out == SQ_LO,
                                $sformatf("square level %0d at full gain", audio_out));
                end else if (n_act == 1 && shp[a] == synth_pkg::SHAPE_SINE && a == last_on) begin
                    expect_true(ph_d3[synth_pkg::PHASE_W-1] ?
                                (audio_out < 0 && audio_out >= -synth_pkg::SAMPLE_MAX) :
                                (audio_out > 0),
                                $sformatf("sine %0d against phase %h", audio_out, ph_d3));
                end else if (n_act == 1 && shp[a] == synth_pkg::SHAPE_SAW) begin
                    expect_true(audio_out >= -synth_pkg::SAMPLE_MAX,
                                $sformatf("saw sample %0d out of range", audio_out));
                end else if (n_act == 2 && shp[a] == synth_pkg::SHAPE_SQUARE &&
                             shp[b] == synth_pkg::SHAPE_SQUARE && frq[a] == frq[b]) begin
                    sat_total++;
                    if (audio_out == synth_pkg::SAMPLE_MAX || audio_out == synth_pkg::SAMPLE_MIN)
                        pinned++;
                end
            end
            if (settle < SETTLE) settle++;
            ph_d3    = ph_d2;                                // Three stage pipe to audio_out
            ph_d2    = ph_d1;
            ph_d1    = ph_model;
            ph_model = on_credit ? '0 : ph_model + frq[last_on];
        end
        if (run_done && !reported) begin
            reported = 1'b1;
            if (pend_q.size() != 0) begin
                error_count++;
                $display("%0d commands were sent but never credited", pend_q.size());
            end
            if (sat_total == 0) begin
                error_count++;
                $display("The two-voice square section was never observed");
            end else begin
                expect_true(pinned * 2 > sat_total,
                            $sformatf("mix pinned in %0d of %0d samples", pinned, sat_total));
            end
            $display("Checker summary: %0d checks, %0d errors", check_count, error_count);
        end
    end

    initial begin
        error_count = 0;
        check_count = 0;
        reported    = 1'b0;
    end

endmodule

// ==== dv/synth_tb.sv ====
module synth_tb;

    localparam int NUM_ROWS = 18;

    logic                             ms_clk;
    logic                             arst_n;
    synth_pkg::note_cmd_t             cmd;
    logic                             cmd_valid;
    logic                             cmd_credit;
    synth_pkg::sample_t               audio_out;
    logic [synth_pkg::NUM_VOICES-1:0] voice_busy;
    logic                             steady;                // Expectation tag of the row
    logic                             run_done;
    int                               error_count;

    synth_pkg::note_cmd_t row_cmd    [NUM_ROWS];
    int                   row_wait   [NUM_ROWS];             // Idle cycles after the send
    logic                 row_steady [NUM_ROWS];
    int                   n_rows;
    int                   sent;
    int                   returned;
    int                   timeout_limit;
    int                   cycle_count = 0;
    int                   seed;

    synth_top synth_top_inst (
        .ms_clk     (ms_clk),
        .arst_n     (arst_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_credit (cmd_credit),
        .audio_out  (audio_out),
        .voice_busy (voice_busy)
    );

    synth_checker synth_checker_inst (
        .ms_clk      (ms_clk),
        .arst_n      (arst_n),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_credit  (cmd_credit),
        .audio_out   (audio_out),
        .voice_busy  (voice_busy),
        .steady      (steady),
        .run_done    (run_done),
        .error_count (error_count)
    );

    initial begin
        ms_clk = 1'b0;
        forever #2 ms_clk = ~ms_clk;
    end

    // Credit return count and the run limit
    always @(posedge ms_clk) begin
        cycle_count <= cycle_count + 1;
        if (!arst_n) returned <= 0;
        else if (cmd_credit) returned <= returned + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    function automatic synth_pkg::phase_t next_freq();
        return synth_pkg::phase_t'($random(seed)) | 24'h1;  // Never a stalled phase
    endfunction

    task automatic add_row(input synth_pkg::note_op_e op, input int voice,
                           input synth_pkg::wave_shape_e shape, input synth_pkg::phase_t freq,
                           input int atk, input int rel, input int wait_cycles, input logic chk);
        row_cmd[n_rows].op           = op;
        row_cmd[n_rows].voice        = synth_pkg::voice_id_t'(voice);
        row_cmd[n_rows].shape        = shape;
        row_cmd[n_rows].freq         = freq;
        row_cmd[n_rows].attack_rate  = synth_pkg::rate_t'(atk);
        row_cmd[n_rows].release_rate = synth_pkg::rate_t'(rel);
        row_wait[n_rows]             = wait_cycles;
        row_steady[n_rows]           = chk;
        n_rows++;
    endtask

    task automatic build_table();
        // Square voice at full attack, then release
        add_row(synth_pkg::OP_NOTE_ON,  0, synth_pkg::SHAPE_SQUARE, next_freq(), 255, 0, 90, 1);
        add_row(synth_pkg::OP_NOTE_OFF, 0, synth_pkg::SHAPE_SQUARE, '0, 0, 64, 140, 0);
        add_row(synth_pkg::OP_NOTE_ON,  1, synth_pkg::SHAPE_SINE, next_freq(), 255, 0, 200, 1);
        add_row(synth_pkg::OP_NOTE_OFF, 1, synth_pkg::SHAPE_SINE, '0, 0, 32, 240, 0);
        // Odd step of the top bits keeps the saw off its most negative code here
        add_row(synth_pkg::OP_NOTE_ON,  2, synth_pkg::SHAPE_SAW, 24'h02A300, 200, 0, 200, 1);
        add_row(synth_pkg::OP_NOTE_OFF, 2, synth_pkg::SHAPE_SAW, '0, 0, 255, 90, 0);
        // Two squares in phase drive the mixer into clipping
        add_row(synth_pkg::OP_NOTE_ON,  0, synth_pkg::SHAPE_SQUARE, 24'h020000, 255, 0, 0, 1);
        add_row(synth_pkg::OP_NOTE_ON,  3, synth_pkg::SHAPE_SQUARE, 24'h020000, 255, 0, 300, 1);
        add_row(synth_pkg::OP_NOTE_OFF, 0, synth_pkg::SHAPE_SQUARE, '0, 0, 128, 0, 0);
        add_row(synth_pkg::OP_NOTE_OFF, 3, synth_pkg::SHAPE_SQUARE, '0, 0, 128, 100, 0);
        // Back to back bursts spend all credits
        for (int v = 0; v < synth_pkg::NUM_VOICES; v++)
            add_row(synth_pkg::OP_NOTE_ON, v, synth_pkg::SHAPE_SINE, next_freq(), 100, 0,
                    (v == synth_pkg::NUM_VOICES - 1) ? 60 : 0, 0);
        for (int v = 0; v < synth_pkg::NUM_VOICES; v++)
            add_row(synth_pkg::OP_NOTE_OFF, v, synth_pkg::SHAPE_SINE, '0, 0, 128,
                    (v == synth_pkg::NUM_VOICES - 1) ? 100 : 0, 0);
    endtask

    // One row, sent only with a credit in hand
    task automatic apply_row(input int idx);
        while (sent - returned >= synth_pkg::CMD_FIFO_DEPTH) begin
            @(posedge ms_clk);
            #1;
        end
        cmd       = row_cmd[idx];
        cmd_valid = 1'b1;
        steady    = row_steady[idx];
        sent++;
        @(posedge ms_clk);
        #1;
        cmd_valid = 1'b0;
        repeat (row_wait[idx]) begin
            @(posedge ms_clk);
            #1;
        end
    endtask

    initial begin
        seed          = 32'h7c93;
        arst_n        = 1'b0;
        cmd           = '0;
        cmd_valid     = 1'b0;
        steady        = 1'b0;
        run_done      = 1'b0;
        sent          = 0;
        n_rows        = 0;
        timeout_limit = 2000;
        build_table();
        for (int i = 0; i < n_rows; i++) timeout_limit += row_wait[i];
        repeat (16) @(posedge ms_clk);
        #1 arst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) apply_row(i);
        repeat (20) @(posedge ms_clk);
        #1 run_done = 1'b1;                                  // Checker closes its books
        repeat (2) @(posedge ms_clk);
        #1;
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog/envelope_gen.sv ====
module envelope_gen (
    input  logic             ms_clk,
    input  logic             arst_n,
    input  logic             note_on,
    input  logic             note_off,
    input  synth_pkg::rate_t attack_rate,
    input  synth_pkg::rate_t release_rate,
    input  logic             env_tick,
    output synth_pkg::gain_t gain,
    output logic             busy
);

    synth_pkg::env_state_e state;
    synth_pkg::rate_t      atk_rate_q;                         // Held from the note-on
    synth_pkg::rate_t      rel_rate_q;                         // Held from the note-off
    synth_pkg::gain_t      atk_step;
    synth_pkg::gain_t      rel_step;
    logic [synth_pkg::GAIN_W:0] up_sum;                        // One extra bit for overflow

    // Zero rate would stall the envelope, so it counts as one
    assign atk_step = synth_pkg::gain_t'((atk_rate_q == '0) ? 8'd1 : atk_rate_q)
                      << synth_pkg::RATE_SHIFT;
    assign rel_step = synth_pkg::gain_t'((rel_rate_q == '0) ? 8'd1 : rel_rate_q)
                      << synth_pkg::RATE_SHIFT;
    assign up_sum   = {1'b0, gain} + {1'b0, atk_step};

    always_ff @(posedge ms_clk) begin
        if (note_on) atk_rate_q <= attack_rate;
        if (note_off) rel_rate_q <= release_rate;
    end

    always_ff @(posedge ms_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= synth_pkg::ENV_IDLE;
            gain  <= '0;
        end else if (note_on) begin                            // Retrigger from any state
            state <= synth_pkg::ENV_ATTACK;
            gain  <= '0;
        end else if (note_off && state != synth_pkg::ENV_IDLE) begin
            state <= synth_pkg::ENV_RELEASE;                   // Gain ramps down from here
        end else if (env_tick) begin
            case (state)
                synth_pkg::ENV_ATTACK: begin
                    if (up_sum >= synth_pkg::GAIN_MAX) begin
                        gain  <= synth_pkg::gain_t'(synth_pkg::GAIN_MAX);
                        state <= synth_pkg::ENV_SUSTAIN;
                    end else begin
                        gain <= up_sum[synth_pkg::GAIN_W-1:0];
                    end
                end
                synth_pkg::ENV_RELEASE: begin
                    if (gain <= rel_step) begin
                        gain  <= '0;
                        state <= synth_pkg::ENV_IDLE;
                    end else begin
                        gain <= gain - rel_step;
                    end
                end
                default: ;                                     // Sustain and idle hold
            endcase
        end
    end

    assign busy = (state != synth_pkg::ENV_IDLE);

    // An idle voice must be silent, the voice relies on it
    a_idle_gain_zero: assert property (@(posedge ms_clk) disable iff (!arst_n)
        (state == synth_pkg::ENV_IDLE) |-> (gain == '0));

endmodule

// ==== verilog/note_dispatch.sv ====
module note_dispatch (
    input  logic                   ms_clk,
    input  logic                   arst_n,
    input  synth_pkg::note_cmd_t   cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_credit,
    output synth_pkg::voice_ctrl_t voice_ctrl [synth_pkg::NUM_VOICES],
    output logic                   env_tick
);

    synth_pkg::note_cmd_t             fifo_mem [synth_pkg::CMD_FIFO_DEPTH];
    logic [synth_pkg::CMD_PTR_W-1:0]  wr_ptr;
    logic [synth_pkg::CMD_PTR_W-1:0]  rd_ptr;
    logic [synth_pkg::CMD_CNT_W-1:0]  fill;                    // Entries held
    logic [synth_pkg::TICK_CNT_W-1:0] tick_cnt;
    synth_pkg::note_cmd_t             head;
    logic                             pop;
    logic [2*synth_pkg::NUM_VOICES-1:0] strobes;               // Every note_on and note_off

    assign head = fifo_mem[rd_ptr];
    assign pop  = (fill != '0);                                // Drain one per cycle

    always_ff @(posedge ms_clk) begin
        if (cmd_valid) fifo_mem[wr_ptr] <= cmd;
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge ms_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (cmd_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({cmd_valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;                                     // Both or neither
            endcase
        end
    end

    // Credit and the voice strobe leave together
    always_ff @(posedge ms_clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_credit <= 1'b0;
            voice_ctrl <= '{default: '0};
        end else begin
            cmd_credit <= pop;
            for (int v = 0; v < synth_pkg::NUM_VOICES; v++) begin
                voice_ctrl[v].note_on  <= pop && (head.op == synth_pkg::OP_NOTE_ON) &&
                                          (head.voice == synth_pkg::voice_id_t'(v));
                voice_ctrl[v].note_off <= pop && (head.op == synth_pkg::OP_NOTE_OFF) &&
                                          (head.voice == synth_pkg::voice_id_t'(v));
                if (pop) begin                                 // Payload goes to all voices
                    voice_ctrl[v].shape        <= head.shape;
                    voice_ctrl[v].freq         <= head.freq;
                    voice_ctrl[v].attack_rate  <= head.attack_rate;
                    voice_ctrl[v].release_rate <= head.release_rate;
                end
            end
        end
    end

    // Envelope tick, one pulse per TICK_DIV cycles
    always_ff @(posedge ms_clk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
            env_tick <= 1'b0;
        end else if (tick_cnt == synth_pkg::TICK_CNT_W'(synth_pkg::TICK_DIV - 1)) begin
            tick_cnt <= '0;
            env_tick <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            env_tick <= 1'b0;
        end
    end

    always_comb begin
        for (int v = 0; v < synth_pkg::NUM_VOICES; v++) begin
            strobes[2*v]   = voice_ctrl[v].note_on;
            strobes[2*v+1] = voice_ctrl[v].note_off;
        end
    end

    // Host must hold back once its credits are spent
    a_no_write_full: assert property (@(posedge ms_clk) disable iff (!arst_n)
        cmd_valid |-> (fill < synth_pkg::CMD_CNT_W'(synth_pkg::CMD_FIFO_DEPTH)));

    // Exactly one voice strobe per credit and none between credits
    a_credit_from_pop: assert property (@(posedge ms_clk) disable iff (!arst_n)
        cmd_credit ? $onehot(strobes) : (strobes == '0));

endmodule

// ==== verilog/synth_pkg.sv ====
package synth_pkg;

    // Voice and command buffer sizing
    localparam int NUM_VOICES     = 4;
    localparam int CMD_FIFO_DEPTH = 4;                           // Also the host's initial credits
    localparam int TICK_DIV       = 24;                          // ms_clk cycles per envelope tick

    // Datapath widths
    localparam int PHASE_W    = 24;
    localparam int SAMPLE_W   = 16;
    localparam int GAIN_W     = 16;
    localparam int RATE_W     = 8;
    localparam int ROM_ADDR_W = 6;                               // Quarter-wave table index
    localparam int VOICE_ID_W = $clog2(NUM_VOICES);
    localparam int MIX_W      = SAMPLE_W + $clog2(NUM_VOICES);   // Headroom for the full sum

    // Derived counter widths
    localparam int CMD_PTR_W  = $clog2(CMD_FIFO_DEPTH);          // Depth is a power of two
    localparam int CMD_CNT_W  = $clog2(CMD_FIFO_DEPTH + 1);
    localparam int TICK_CNT_W = $clog2(TICK_DIV);

    // Amplitude limits
    localparam int SAMPLE_MAX = 32767;
    localparam int SAMPLE_MIN = -32768;
    localparam int GAIN_MAX   = 65535;
    localparam int RATE_SHIFT = 8;                               // Envelope step is rate * 256

    // First quadrant of sine, sampled at bin centres so no entry is zero
    localparam logic [SAMPLE_W-2:0] SINE_QTAB [2**ROM_ADDR_W] = '{
          402,  1206,  2009,  2811,  3612,  4410,  5205,  5998,
         6786,  7571,  8351,  9126,  9896, 10659, 11417, 12167,
        12910, 13645, 14372, 15090, 15800, 16499, 17189, 17869,
        18537, 19195, 19841, 20475, 21096, 21705, 22301, 22884,
        23452, 24007, 24547, 25072, 25582, 26077, 26556, 27019,
        27466, 27896, 28310, 28706, 29085, 29447, 29791, 30117,
        30424, 30714, 30985, 31237, 31470, 31685, 31880, 32057,
        32213, 32351, 32469, 32567, 32646, 32705, 32745, 32765
    };

    typedef logic        [PHASE_W-1:0]    phase_t;      // Phase and per-cycle increment
    typedef logic signed [SAMPLE_W-1:0]   sample_t;
    typedef logic        [GAIN_W-1:0]     gain_t;
    typedef logic        [RATE_W-1:0]     rate_t;       // Gain step per tick, in units of 256
    typedef logic        [VOICE_ID_W-1:0] voice_id_t;
    typedef logic signed [MIX_W-1:0]      mix_t;

    typedef enum logic [1:0] {
        SHAPE_SINE,
        SHAPE_SQUARE,
        SHAPE_SAW
    } wave_shape_e;

    typedef enum logic {
        OP_NOTE_ON,
        OP_NOTE_OFF
    } note_op_e;

    typedef enum logic [1:0] {
        ENV_IDLE,
        ENV_ATTACK,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_e;

    // One host command
    typedef struct packed {
        note_op_e    op;
        voice_id_t   voice;
        wave_shape_e shape;
        phase_t      freq;
        rate_t       attack_rate;
        rate_t       release_rate;
    } note_cmd_t;

    // Per-voice strobes plus the payload of the popped command
    typedef struct packed {
        logic        note_on;
        logic        note_off;
        wave_shape_e shape;
        phase_t      freq;
        rate_t       attack_rate;
        rate_t       release_rate;
    } voice_ctrl_t;

endpackage

// ==== verilog/synth_top.sv ====
module synth_top (
    input  logic                            ms_clk,
    input  logic                            arst_n,
    input  synth_pkg::note_cmd_t            cmd,
    input  logic                            cmd_valid,
    output logic                            cmd_credit,
    output synth_pkg::sample_t              audio_out,
    output logic [synth_pkg::NUM_VOICES-1:0] voice_busy
);

    synth_pkg::voice_ctrl_t voice_ctrl   [synth_pkg::NUM_VOICES];
    synth_pkg::sample_t     voice_sample [synth_pkg::NUM_VOICES];
    logic                   env_tick;                          // Shared by every envelope

    note_dispatch note_dispatch_inst (
        .ms_clk     (ms_clk),
        .arst_n     (arst_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_credit (cmd_credit),
        .voice_ctrl (voice_ctrl),
        .env_tick   (env_tick)
    );

    // One oscillator per voice slot
    for (genvar g = 0; g < synth_pkg::NUM_VOICES; g++) begin : g_voice
        voice_osc voice_osc_inst (
            .ms_clk   (ms_clk),
            .arst_n   (arst_n),
            .ctrl     (voice_ctrl[g]),
            .env_tick (env_tick),
            .sample   (voice_sample[g]),
            .busy     (voice_busy[g])
        );
    end

    voice_mixer voice_mixer_inst (
        .ms_clk       (ms_clk),
        .arst_n       (arst_n),
        .voice_sample (voice_sample),
        .audio_out    (audio_out)
    );

endmodule

// ==== verilog/voice_mixer.sv ====
module voice_mixer (
    input  logic               ms_clk,
    input  logic               arst_n,
    input  synth_pkg::sample_t voice_sample [synth_pkg::NUM_VOICES],
    output synth_pkg::sample_t audio_out
);

    synth_pkg::mix_t mix_sum;                                  // Cannot overflow at this width

    always_comb begin
        mix_sum = '0;
        for (int v = 0; v < synth_pkg::NUM_VOICES; v++) begin
            mix_sum = mix_sum + voice_sample[v];               // Sign-extended add
        end
    end

    // Clip to the sample range
    always_ff @(posedge ms_clk or negedge arst_n) begin
        if (!arst_n) begin
            audio_out <= '0;
        end else if (mix_sum > synth_pkg::SAMPLE_MAX) begin
            audio_out <= synth_pkg::sample_t'(synth_pkg::SAMPLE_MAX);
        end else if (mix_sum < synth_pkg::SAMPLE_MIN) begin
            audio_out <= synth_pkg::sample_t'(synth_pkg::SAMPLE_MIN);
        end else begin
            audio_out <= synth_pkg::sample_t'(mix_sum);
        end
    end

endmodule

// ==== verilog/voice_osc.sv ====
module voice_osc (
    input  logic                   ms_clk,
    input  logic                   arst_n,
    input  synth_pkg::voice_ctrl_t ctrl,
    input  logic                   env_tick,
    output synth_pkg::sample_t     sample,
    output logic                   busy
);

    synth_pkg::phase_t      phase;
    synth_pkg::phase_t      freq_q;
    synth_pkg::wave_shape_e shape_q;
    synth_pkg::wave_shape_e shape_d1;                          // Aligned with the ROM output
    synth_pkg::sample_t     sine_data;
    synth_pkg::sample_t     alt_q;                             // Square or saw, registered
    synth_pkg::sample_t     wave;
    synth_pkg::gain_t       gain;
    logic signed [synth_pkg::SAMPLE_W+synth_pkg::GAIN_W:0] scaled;

    // Phase accumulator, wraps naturally
    always_ff @(posedge ms_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase   <= '0;
            shape_q <= synth_pkg::SHAPE_SINE;
        end else if (ctrl.note_on) begin
            phase   <= '0;                                     // Every note starts at phase 0
            shape_q <= ctrl.shape;
        end else if (busy) begin
            phase <= phase + freq_q;
        end
    end

    always_ff @(posedge ms_clk) begin
        if (ctrl.note_on) freq_q <= ctrl.freq;
    end

    wave_rom wave_rom_inst (
        .ms_clk (ms_clk),
        .phase  (phase),
        .data   (sine_data)
    );

    // Computed shapes share the ROM's one-cycle latency
    always_ff @(posedge ms_clk) begin
        shape_d1 <= shape_q;
        if (shape_q == synth_pkg::SHAPE_SQUARE) begin
            alt_q <= phase[synth_pkg::PHASE_W-1] ?
                     -synth_pkg::sample_t'(synth_pkg::SAMPLE_MAX) :
                      synth_pkg::sample_t'(synth_pkg::SAMPLE_MAX);
        end else begin
            alt_q <= phase[synth_pkg::PHASE_W-1 -: synth_pkg::SAMPLE_W];  // Saw, top bits signed
        end
    end

    assign wave = (shape_d1 == synth_pkg::SHAPE_SINE) ? sine_data : alt_q;

    envelope_gen envelope_gen_inst (
        .ms_clk       (ms_clk),
        .arst_n       (arst_n),
        .note_on      (ctrl.note_on),
        .note_off     (ctrl.note_off),
        .attack_rate  (ctrl.attack_rate),
        .release_rate (ctrl.release_rate),
        .env_tick     (env_tick),
        .gain         (gain),
        .busy         (busy)
    );

    // Gain is unsigned, widen it with a zero sign bit
    assign scaled = wave * $signed({1'b0, gain});

    // Idle gain is zero so this is silent when idle
    always_ff @(posedge ms_clk or negedge arst_n) begin
        if (!arst_n) begin
            sample <= '0;
        end else begin
            sample <= synth_pkg::sample_t'(scaled >>> synth_pkg::GAIN_W);
        end
    end

endmodule

// ==== verilog/wave_rom.sv ====
module wave_rom (
    input  logic               ms_clk,
    input  synth_pkg::phase_t  phase,
    output synth_pkg::sample_t data
);

    logic [1:0]                       quadrant;
    logic [synth_pkg::ROM_ADDR_W-1:0] raw_addr;
    logic [synth_pkg::ROM_ADDR_W-1:0] addr;
    logic [synth_pkg::SAMPLE_W-2:0]   mag;
    synth_pkg::sample_t               mag_s;

    // Top two phase bits pick the quadrant
    assign quadrant = phase[synth_pkg::PHASE_W-1 -: 2];

    // Next bits index inside the quarter wave
    assign raw_addr = phase[synth_pkg::PHASE_W-3 -: synth_pkg::ROM_ADDR_W];

    // Quadrants 1 and 3 run the table backwards
    assign addr  = quadrant[0] ? ~raw_addr : raw_addr;
    assign mag   = synth_pkg::SINE_QTAB[addr];
    assign mag_s = synth_pkg::sample_t'({1'b0, mag});          // Always positive here

    // Second half of the period is the negative lobe
    always_ff @(posedge ms_clk) begin
        data <= quadrant[1] ? -mag_s : mag_s;
    end

endmodule
